// ==== verilog/sgb_pkg.sv ====
package sgb_pkg;

  //----------------------------------------------------------------------
  // widths that carry a meaning
  //----------------------------------------------------------------------
  typedef logic [7:0]  byte_t;       // data byte on the host bus
  typedef logic [15:0] host_addr_t;  // host register address
  typedef logic [1:0]  pad_id_t;     // pad number 0..3
  typedef logic [1:0]  clk_mult_t;   // divisor select, 0..3 -> 16,20,28,36
  typedef logic [6:0]  bit_pos_t;    // [6:3] byte index, [2:0] bit, lsb first
  typedef logic [3:0]  pkt_idx_t;    // packet byte index

  // joypad / serial receive states
  typedef enum logic [1:0] {
    BTN_IDLE,  // button mode
    BTN_RECV,  // expecting a data bit (01 or 10)
    BTN_WAIT   // expecting 11, or the 10 terminator
  } btn_state_t;

  //----------------------------------------------------------------------
  // sizes and clocking
  //----------------------------------------------------------------------
  localparam int PKT_BYTES   = 16;   // bytes per serial packet
  localparam int PAD_CNT     = 4;    // joypads served
  localparam int SKIP_PERIOD = 737;  // base clocks per skip cycle
  localparam int CPU_DIV_0   = 16;   // base clocks per cpu edge, /4
  localparam int CPU_DIV_1   = 20;   // /5, default
  localparam int CPU_DIV_2   = 28;   // /7
  localparam int CPU_DIV_3   = 36;   // /9

  //----------------------------------------------------------------------
  // host register map and reset values
  //----------------------------------------------------------------------
  localparam host_addr_t ADDR_PKTRDY   = 16'h6002;  // r, packet ready in bit 0
  localparam host_addr_t ADDR_CTL      = 16'h6003;  // r/w control
  localparam host_addr_t ADDR_PAD0     = 16'h6004;  // pads at 6004..6007
  localparam host_addr_t ADDR_VER      = 16'h600F;  // r, version
  localparam host_addr_t ADDR_PKT_BASE = 16'h7000;  // packet bytes 7000..700F

  localparam byte_t CTL_RESET = 8'h01;  // cpu held in reset, divisor 20
  localparam byte_t PAD_RESET = 8'hFF;  // nothing pressed (active low)
  localparam byte_t VERSION   = 8'h61;

endpackage

// ==== verilog/cpu_clock_gen.sv ====
`timescale 1ns/10ps

module cpu_clock_gen (
  input  logic                CLK,
  input  logic                cpu_ireset_r,
  input  sgb_pkg::clk_mult_t  clk_mult,      // from control[1:0]
  output logic                cpu_clk_edge   // one-cycle pulse per cpu clock
);

  logic [9:0]         skp_ctr_r;    // counts base clocks up to the skip
  logic [5:0]         cpu_ctr_r;    // base clocks within one cpu clock
  logic [5:0]         div_last;     // terminal count for selected divisor
  logic [1:0]         bus_ctr_r;    // cpu edges within one bus clock
  sgb_pkg::clk_mult_t clk_mult_r;   // divisor select in use
  logic               skp_ast;
  logic               cpu_ast;
  logic               bus_edge;
  logic               edge_r;

  // terminal count is divisor minus one
  always_comb begin
    case (clk_mult_r)
      2'd0:    div_last = 6'(sgb_pkg::CPU_DIV_0 - 1);
      2'd1:    div_last = 6'(sgb_pkg::CPU_DIV_1 - 1);
      2'd2:    div_last = 6'(sgb_pkg::CPU_DIV_2 - 1);
      default: div_last = 6'(sgb_pkg::CPU_DIV_3 - 1);
    endcase
  end

  assign skp_ast  = (skp_ctr_r == 10'(sgb_pkg::SKIP_PERIOD - 1));  // 736
  assign cpu_ast  = ~skp_ast & (cpu_ctr_r == div_last);  // never on a skip clock
  assign bus_edge = edge_r & (&bus_ctr_r);              // every fourth cpu edge

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      skp_ctr_r  <= '0;
      cpu_ctr_r  <= '0;
      edge_r     <= 1'b0;
      bus_ctr_r  <= '0;
      clk_mult_r <= sgb_pkg::clk_mult_t'(sgb_pkg::CTL_RESET[1:0]);
    end else begin
      skp_ctr_r <= skp_ast ? '0 : skp_ctr_r + 10'd1;
      // the skip clock stalls the cpu counter, so that spacing grows by one
      if (!skp_ast) begin
        cpu_ctr_r <= cpu_ast ? '0 : cpu_ctr_r + 6'd1;
      end
      edge_r <= cpu_ast;  // edge lands one cycle after the match
      if (edge_r) begin
        bus_ctr_r <= bus_ctr_r + 2'd1;
      end
      // divisor only changes on a bus edge
      if (bus_edge) begin
        clk_mult_r <= clk_mult;
      end
    end
  end

  assign cpu_clk_edge = edge_r;

endmodule

// ==== verilog/joypad_serial_rx.sv ====
`timescale 1ns/10ps

module joypad_serial_rx (
  input  logic               CLK,
  input  logic               cpu_ireset_r,
  input  logic               cpu_clk_edge,
  input  logic [1:0]         p1i,                          // select lines from handheld
  input  sgb_pkg::byte_t     pad_data [sgb_pkg::PAD_CNT],  // active-low buttons
  input  sgb_pkg::pad_id_t   player_mask,
  output logic [3:0]         p1o,                          // answer nibble
  output logic               idl,
  output logic               bit_we,
  output sgb_pkg::bit_pos_t  bit_pos,
  output logic               bit_val,
  output logic               pkt_done                      // one-cycle pulse
);

  sgb_pkg::btn_state_t state_r;     // current state
  sgb_pkg::btn_state_t pend_r;      // state to enter after the next WAIT
  logic [1:0]          prev_r;      // p1i at the last cpu edge
  sgb_pkg::pad_id_t    cur_id_r;    // pad being answered
  sgb_pkg::bit_pos_t   pos_r;       // next packet bit
  sgb_pkg::bit_pos_t   wr_pos_r;
  logic                wr_val_r;
  logic                wr_en_r;
  logic                done_r;
  logic                p1i_chg;
  logic                term_pend;
  sgb_pkg::byte_t      cur_pad;

  assign p1i_chg   = cpu_clk_edge & (p1i != prev_r);
  assign term_pend = (pend_r == sgb_pkg::BTN_IDLE);  // 10 ends the packet
  assign cur_pad   = pad_data[cur_id_r];

  //----------------------------------------------------------------------
  // answer to the handheld
  //----------------------------------------------------------------------
  // 11 -> ~id (F,E,D,C), 01 -> buttons [7:4], 10 -> d-pad [3:0]
  assign p1o = (&p1i) ? ~{2'b00, cur_id_r}
                      : (({4{p1i[1]}} | cur_pad[7:4]) & ({4{p1i[0]}} | cur_pad[3:0]));

  // halt hint: idle, or waiting before the first bit
  assign idl = (state_r == sgb_pkg::BTN_IDLE) |
               ((state_r == sgb_pkg::BTN_WAIT) & ~|pos_r);

  //----------------------------------------------------------------------
  // select line FSM
  //----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      state_r  <= sgb_pkg::BTN_IDLE;
      pend_r   <= sgb_pkg::BTN_IDLE;
      prev_r   <= 2'b00;
      cur_id_r <= '0;
      pos_r    <= '0;
      wr_en_r  <= 1'b0;
      done_r   <= 1'b0;
    end else begin
      wr_en_r <= 1'b0;  // pulses
      done_r  <= 1'b0;
      if (cpu_clk_edge) begin
        prev_r <= p1i;
      end
      if (p1i_chg) begin
        if (p1i == 2'b00) begin
          // any state -> 00 starts a packet
          pos_r   <= '0;
          pend_r  <= sgb_pkg::BTN_RECV;
          state_r <= sgb_pkg::BTN_WAIT;
        end else begin
          case (state_r)
            sgb_pkg::BTN_IDLE: begin
              if (~prev_r[1] & p1i[1]) begin  // rise of p1i[1] steps the pad
                cur_id_r <= (cur_id_r + 2'd1) & player_mask;
              end
            end
            sgb_pkg::BTN_RECV: begin
              if (^p1i) begin  // 01 -> 1, 10 -> 0; 11 is a nop
                wr_en_r  <= 1'b1;
                wr_pos_r <= pos_r;
                wr_val_r <= p1i[0];
                pos_r    <= pos_r + 7'd1;
                // bit 127 done, the next WAIT arms the terminator
                pend_r   <= (&pos_r) ? sgb_pkg::BTN_WAIT : sgb_pkg::BTN_RECV;
                state_r  <= sgb_pkg::BTN_WAIT;
              end
            end
            sgb_pkg::BTN_WAIT: begin
              if (p1i == {1'b1, ~term_pend}) begin  // 11, or 10 as terminator
                done_r  <= term_pend;
                pend_r  <= sgb_pkg::BTN_IDLE;
                state_r <= pend_r;
              end else if (^p1i) begin
                state_r <= sgb_pkg::BTN_IDLE;  // protocol error, drop packet
              end
            end
            default: state_r <= sgb_pkg::BTN_IDLE;
          endcase
        end
      end
    end
  end

  assign bit_we   = wr_en_r;
  assign bit_pos  = wr_pos_r;
  assign bit_val  = wr_val_r;
  assign pkt_done = done_r;

endmodule

// ==== verilog/packet_buffer.sv ====
`timescale 1ns/10ps

module packet_buffer (
  input  logic               CLK,
  input  logic               cpu_ireset_r,
  input  logic               bit_we,        // write one packet bit
  input  sgb_pkg::bit_pos_t  bit_pos,
  input  logic               bit_val,
  input  logic               pkt_done,      // sets ready
  input  sgb_pkg::pkt_idx_t  rd_idx,
  output sgb_pkg::byte_t     rd_byte,
  input  logic               pkt_rd_clear,  // clears ready
  output logic               pkt_ready
);

  sgb_pkg::byte_t pkt_r [sgb_pkg::PKT_BYTES];  // packet bytes, 7000..700F
  logic           ready_r;

  //----------------------------------------------------------------------
  // bit-wise store
  //----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      for (int i = 0; i < sgb_pkg::PKT_BYTES; i++) begin
        pkt_r[i] <= '0;
      end
    end else if (bit_we) begin
      pkt_r[bit_pos[6:3]][bit_pos[2:0]] <= bit_val;  // byte index, then bit
    end
  end

  assign rd_byte = pkt_r[rd_idx];  // combinational, host regs flop it

  // ready flag, a set in the same cycle as a clear wins
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      ready_r <= 1'b0;
    end else begin
      ready_r <= (ready_r & ~pkt_rd_clear) | pkt_done;
    end
  end

  assign pkt_ready = ready_r;

endmodule

// ==== verilog/icd2_host_regs.sv ====
`timescale 1ns/10ps

module icd2_host_regs (
  input  logic                CLK,
  input  logic                cpu_ireset_r,
  input  sgb_pkg::host_addr_t host_addr,
  input  sgb_pkg::byte_t      host_data_in,
  input  logic                host_rd_start,
  input  logic                host_wr_end,
  output sgb_pkg::byte_t      host_data_out,
  output sgb_pkg::pkt_idx_t   rd_idx,
  input  sgb_pkg::byte_t      rd_byte,
  input  logic                pkt_ready,
  output logic                pkt_rd_clear,
  output sgb_pkg::byte_t      pad_data [sgb_pkg::PAD_CNT],
  output sgb_pkg::pad_id_t    player_mask,
  output sgb_pkg::clk_mult_t  clk_mult,
  output logic                cpu_rst
);

  sgb_pkg::byte_t ctl_r;                     // 6003
  sgb_pkg::byte_t pad_r [sgb_pkg::PAD_CNT];  // 6004..6007
  sgb_pkg::byte_t mdr_r;                     // read data, held until next read
  logic           clr_r;
  logic           is_pktrdy;
  logic           is_ctl;
  logic           is_pad;
  logic           is_ver;
  logic           is_pkt;

  //----------------------------------------------------------------------
  // address decode
  //----------------------------------------------------------------------
  assign is_pktrdy = (host_addr == sgb_pkg::ADDR_PKTRDY);
  assign is_ctl    = (host_addr == sgb_pkg::ADDR_CTL);
  assign is_pad    = (host_addr[15:2] == sgb_pkg::ADDR_PAD0[15:2]);      // 4 pads
  assign is_ver    = (host_addr == sgb_pkg::ADDR_VER);
  assign is_pkt    = (host_addr[15:4] == sgb_pkg::ADDR_PKT_BASE[15:4]);  // 16 bytes

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      ctl_r <= sgb_pkg::CTL_RESET;
      for (int i = 0; i < sgb_pkg::PAD_CNT; i++) begin
        pad_r[i] <= sgb_pkg::PAD_RESET;
      end
      mdr_r <= '0;
      clr_r <= 1'b0;
    end else begin
      clr_r <= 1'b0;
      // pads past the player count read as released
      case (ctl_r[5:4])
        2'd0: begin
          pad_r[1] <= sgb_pkg::PAD_RESET;
          pad_r[2] <= sgb_pkg::PAD_RESET;
          pad_r[3] <= sgb_pkg::PAD_RESET;
        end
        2'd1: begin
          pad_r[2] <= sgb_pkg::PAD_RESET;
          pad_r[3] <= sgb_pkg::PAD_RESET;
        end
        default: ;  // 2 or 4 players, no forcing
      endcase
      // writes, taking effect next cycle
      if (host_wr_end) begin
        if (is_ctl) begin
          ctl_r <= {host_data_in[7], 1'b0, host_data_in[5:4], 2'b00, host_data_in[1:0]};
        end else if (is_pad) begin
          pad_r[host_addr[1:0]] <= host_data_in;
        end
      end
      // flop read data early so later writes cannot disturb the bus
      if (host_rd_start) begin
        if (is_pktrdy) begin
          mdr_r <= {7'b0, pkt_ready};
        end else if (is_ctl) begin
          mdr_r <= ctl_r;
        end else if (is_pad) begin
          mdr_r <= pad_r[host_addr[1:0]];
        end else if (is_ver) begin
          mdr_r <= sgb_pkg::VERSION;
        end else if (is_pkt) begin
          mdr_r <= rd_byte;
          clr_r <= (host_addr[3:0] == 4'h0);  // first byte read acks the packet
        end
      end
    end
  end

  assign host_data_out = mdr_r;
  assign rd_idx        = host_addr[3:0];
  assign pkt_rd_clear  = clr_r;
  assign pad_data      = pad_r;
  assign cpu_rst       = ~ctl_r[7];   // bit 7 releases the cpu
  assign player_mask   = ctl_r[5:4];  // 0:1, 1:2, 3:4 players
  assign clk_mult      = ctl_r[1:0];

endmodule

// ==== verilog/sgb_icd2.sv ====
`timescale 1ns/10ps

module sgb_icd2 (
  input  logic                CLK,
  input  logic                cpu_ireset_r,
  // host register port
  input  sgb_pkg::host_addr_t host_addr,
  input  sgb_pkg::byte_t      host_data_in,
  input  logic                host_rd_start,
  input  logic                host_wr_end,
  output sgb_pkg::byte_t      host_data_out,
  // handheld side
  input  logic [1:0]          p1i,
  output logic [3:0]          p1o,
  output logic                idl,
  output logic                cpu_rst,
  output logic                cpu_clk_edge
);

  sgb_pkg::clk_mult_t clk_mult;
  sgb_pkg::byte_t     pad_data [sgb_pkg::PAD_CNT];
  sgb_pkg::pad_id_t   player_mask;
  logic               bit_we;
  sgb_pkg::bit_pos_t  bit_pos;
  logic               bit_val;
  logic               pkt_done;
  sgb_pkg::pkt_idx_t  rd_idx;
  sgb_pkg::byte_t     rd_byte;
  logic               pkt_rd_clear;
  logic               pkt_ready;

  //----------------------------------------------------------------------
  // clocking, receiver, packet store, host registers
  //----------------------------------------------------------------------
  cpu_clock_gen cpu_clock_gen_i (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .clk_mult     (clk_mult),
    .cpu_clk_edge (cpu_clk_edge)
  );

  joypad_serial_rx joypad_serial_rx_i (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .cpu_clk_edge (cpu_clk_edge),
    .p1i          (p1i),
    .pad_data     (pad_data),
    .player_mask  (player_mask),
    .p1o          (p1o),
    .idl          (idl),
    .bit_we       (bit_we),
    .bit_pos      (bit_pos),
    .bit_val      (bit_val),
    .pkt_done     (pkt_done)
  );

  packet_buffer packet_buffer_i (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .bit_we       (bit_we),
    .bit_pos      (bit_pos),
    .bit_val      (bit_val),
    .pkt_done     (pkt_done),
    .rd_idx       (rd_idx),
    .rd_byte      (rd_byte),
    .pkt_rd_clear (pkt_rd_clear),
    .pkt_ready    (pkt_ready)
  );

  icd2_host_regs icd2_host_regs_i (
    .CLK           (CLK),
    .cpu_ireset_r  (cpu_ireset_r),
    .host_addr     (host_addr),
    .host_data_in  (host_data_in),
    .host_rd_start (host_rd_start),
    .host_wr_end   (host_wr_end),
    .host_data_out (host_data_out),
    .rd_idx        (rd_idx),
    .rd_byte       (rd_byte),
    .pkt_ready     (pkt_ready),
    .pkt_rd_clear  (pkt_rd_clear),
    .pad_data      (pad_data),
    .player_mask   (player_mask),
    .clk_mult      (clk_mult),
    .cpu_rst       (cpu_rst)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
  output logic CLK,
  output logic cpu_ireset_r
);

  initial begin
    CLK          = 1'b0;
    cpu_ireset_r = 1'b1;          // reset held from time zero
    repeat (8) @(posedge CLK);    // 8 full cycles
    cpu_ireset_r <= 1'b0;
  end

  always #50 CLK = ~CLK;          // 100 ns period

endmodule

// ==== sim/sgb_icd2_checker.sv ====
`timescale 1ns/10ps

module sgb_icd2_checker (
  input  logic       CLK,
  input  logic       cpu_ireset_r,
  input  logic [7:0] host_data_out,
  input  logic [3:0] p1o,
  input  logic       idl,
  input  logic       cpu_rst,
  input  logic       cpu_clk_edge,
  input  logic       chk_en,    // compare on this cycle
  input  logic [1:0] chk_sig,   // 0 data, 1 p1o, 2 idl, 3 cpu_rst
  input  logic [7:0] chk_exp,
  input  logic       gap_en,    // measure edge spacing
  input  logic [7:0] gap_div,
  input  int         assert_errs,  // failures of the bound assertions
  input  logic       report,
  output int         err_cnt
);

  int   data_errs = 0;
  int   p1o_errs  = 0;
  int   flag_errs = 0;
  int   gap_errs  = 0;
  int   gap_cnt   = 0;        // cycles since last cpu edge
  logic gap_seen  = 1'b0;

  assign err_cnt = data_errs + p1o_errs + flag_errs + gap_errs + assert_errs;

  //----------------------------------------------------------------------
  // value compares, sampled one cycle after the request
  //----------------------------------------------------------------------
  always @(posedge CLK) begin
    if (chk_en) begin
      case (chk_sig)
        2'd0: if (host_data_out !== chk_exp) begin
          $display("ERR host_data_out exp=%h got=%h", chk_exp, host_data_out);
          data_errs++;
        end
        2'd1: if ({4'h0, p1o} !== chk_exp) begin
          $display("ERR p1o exp=%h got=%h", chk_exp[3:0], p1o);
          p1o_errs++;
        end
        2'd2: if (idl !== chk_exp[0]) begin
          $display("ERR idl exp=%h got=%h", chk_exp[0], idl);
          flag_errs++;
        end
        default: if (cpu_rst !== chk_exp[0]) begin
          $display("ERR cpu_rst exp=%h got=%h", chk_exp[0], cpu_rst);
          flag_errs++;
        end
      endcase
    end
    if (report) begin
      $display("checker: %0d data, %0d p1o, %0d flag, %0d gap, %0d assertion errors",
               data_errs, p1o_errs, flag_errs, gap_errs, assert_errs);
    end
  end

  //----------------------------------------------------------------------
  // cpu edge spacing, divisor or divisor plus one on a skip
  //----------------------------------------------------------------------
  always @(posedge CLK) begin
    if (cpu_ireset_r) begin
      gap_seen = 1'b0;
      gap_cnt  = 0;
    end else if (cpu_clk_edge) begin
      if (gap_en && gap_seen && gap_cnt != gap_div && gap_cnt != gap_div + 1) begin
        $display("ERR cpu_clk_edge gap exp=%h got=%h", gap_div, gap_cnt);
        gap_errs++;
      end
      gap_cnt  = 1;
      gap_seen = 1'b1;
    end else begin
      gap_cnt++;
    end
  end

endmodule

// ==== sim/sgb_icd2_assertions.sv ====
`timescale 1ns/10ps

module sgb_icd2_assertions (
  input logic CLK,
  input logic cpu_ireset_r,
  input logic pkt_done,
  input logic pkt_ready,
  input logic cpu_clk_edge,
  input logic cpu_rst
);

  int fail_cnt = 0;  // failed assertions so far

  // ready is only ever set by a done pulse
  a_ready_src: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    $rose(pkt_ready) |-> $past(pkt_done))
    else begin
      $error("pkt_ready rose without pkt_done");
      fail_cnt++;
    end

  a_edge_pulse: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    cpu_clk_edge |=> !cpu_clk_edge)   // single-cycle pulse
    else begin
      $error("cpu_clk_edge longer than one cycle");
      fail_cnt++;
    end

  // control resets to 01, bit 7 low keeps the cpu in reset
  a_rst_hold: assert property (@(posedge CLK) $fell(cpu_ireset_r) |-> cpu_rst)
    else begin
      $error("cpu_rst not held after reset");
      fail_cnt++;
    end

endmodule

bind sgb_icd2 sgb_icd2_assertions sgb_icd2_assertions_i (
  .CLK          (CLK),
  .cpu_ireset_r (cpu_ireset_r),
  .pkt_done     (pkt_done),
  .pkt_ready    (pkt_ready),
  .cpu_clk_edge (cpu_clk_edge),
  .cpu_rst      (cpu_rst)
);

// ==== sim/tb_sgb_icd2.sv ====
`timescale 1ns/10ps

module tb_sgb_icd2;

  localparam logic [2:0] OP_RD   = 0;
  localparam logic [2:0] OP_WR   = 1;
  localparam logic [2:0] OP_P1O  = 2;
  localparam logic [2:0] OP_P1S  = 3;
  localparam logic [2:0] OP_PKT  = 4;
  localparam logic [2:0] OP_PKRD = 5;
  localparam logic [2:0] OP_FLAG = 6;
  localparam logic [2:0] OP_GAP  = 7;

  typedef struct packed {
    logic [2:0]  op;
    logic [15:0] addr;
    logic [7:0]  data;
    logic [7:0]  exp;
  } step_t;

  logic                CLK;
  logic                cpu_ireset_r;
  sgb_pkg::host_addr_t host_addr;
  sgb_pkg::byte_t      host_data_in;
  logic                host_rd_start;
  logic                host_wr_end;
  sgb_pkg::byte_t      host_data_out;
  logic [1:0]          p1i;
  logic [3:0]          p1o;
  logic                idl;
  logic                cpu_rst;
  logic                cpu_clk_edge;
  logic                chk_en;
  logic [1:0]          chk_sig;
  logic [7:0]          chk_exp;
  logic                gap_en;
  logic [7:0]          gap_div;
  logic                report;
  int                  err_cnt;

  step_t          steps [$];              // stimulus table
  logic [15:0]    lfsr;
  sgb_pkg::byte_t pkt_exp [16];           // bytes of the last packet sent
  sgb_pkg::byte_t pad_model [4];
  logic [1:0]     id_model;
  logic [1:0]     mask_model;
  logic [1:0]     prev_model;
  int             cycles = 0;
  int             limit  = 0;
  int             n_pkt  = 0;

  tb_clock_gen tb_clock_gen_i (.CLK(CLK), .cpu_ireset_r(cpu_ireset_r));

  sgb_icd2 sgb_icd2_i (
    .CLK (CLK), .cpu_ireset_r (cpu_ireset_r),
    .host_addr (host_addr), .host_data_in (host_data_in),
    .host_rd_start (host_rd_start), .host_wr_end (host_wr_end),
    .host_data_out (host_data_out),
    .p1i (p1i), .p1o (p1o), .idl (idl), .cpu_rst (cpu_rst), .cpu_clk_edge (cpu_clk_edge)
  );

  sgb_icd2_checker sgb_icd2_checker_i (
    .CLK (CLK), .cpu_ireset_r (cpu_ireset_r), .host_data_out (host_data_out),
    .p1o (p1o), .idl (idl), .cpu_rst (cpu_rst), .cpu_clk_edge (cpu_clk_edge),
    .chk_en (chk_en), .chk_sig (chk_sig), .chk_exp (chk_exp),
    .gap_en (gap_en), .gap_div (gap_div),
    .assert_errs (sgb_icd2_i.sgb_icd2_assertions_i.fail_cnt),
    .report (report), .err_cnt (err_cnt)
  );

  // galois form, one step per payload bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic add(input logic [2:0] op, input logic [15:0] a,
                     input logic [7:0] d, input logic [7:0] e);
    step_t s;
    s = {op, a, d, e};
    steps.push_back(s);
  endtask

  //----------------------------------------------------------------------
  // bus and select line drivers, all entered just after a rising edge
  //----------------------------------------------------------------------
  task automatic expect_val(input logic [1:0] sig, input logic [7:0] e);
    chk_en  <= 1'b1;
    chk_sig <= sig;
    chk_exp <= e;
    @(posedge CLK);   // checker samples here
    chk_en  <= 1'b0;
  endtask

  task automatic host_read(input logic [15:0] a, input logic [7:0] e);
    host_addr     <= a;
    host_rd_start <= 1'b1;
    @(posedge CLK);
    host_rd_start <= 1'b0;
    expect_val(2'd0, e);
  endtask

  task automatic host_write(input logic [15:0] a, input logic [7:0] d);
    host_addr    <= a;
    host_data_in <= d;
    host_wr_end  <= 1'b1;
    @(posedge CLK);
    host_wr_end  <= 1'b0;
    @(posedge CLK);   // register updated
  endtask

  task automatic wait_edge();
    do @(negedge CLK); while (!cpu_clk_edge);
    @(posedge CLK);   // edge consumed here
  endtask

  task automatic drive_p1i(input logic [1:0] v);
    p1i <= v;
    wait_edge();
  endtask

  task automatic send_packet();
    logic b;
    drive_p1i(2'b00);    // start
    drive_p1i(2'b11);
    for (int i = 0; i < 128; i++) begin
      b                    = lfsr[0];
      lfsr                 = lfsr_next(lfsr);
      pkt_exp[i/8][i%8]    = b;
      drive_p1i(b ? 2'b01 : 2'b10);   // p1i[0] is the bit
      drive_p1i(2'b11);
    end
    drive_p1i(2'b10);    // terminator
    prev_model = 2'b10;
    repeat (2) @(posedge CLK);  // done, then ready
  endtask

  task automatic run_step(input step_t s);
    logic [7:0] e;
    logic [1:0] v;
    v = s.data[1:0];
    case (s.op)
      OP_RD:   host_read(s.addr, s.exp);
      OP_PKRD: host_read(s.addr, pkt_exp[s.exp[3:0]]);
      OP_WR: begin
        host_write(s.addr, s.data);
        if (s.addr == sgb_pkg::ADDR_CTL) mask_model = s.data[5:4];
        else if (!(mask_model == 0 && s.addr[1:0] != 0) &&
                 !(mask_model == 1 && s.addr[1]))
          pad_model[s.addr[1:0]] = s.data;
        if (mask_model == 0) pad_model[1] = 8'hFF;   // unused pads released
        if (mask_model <= 1) begin
          pad_model[2] = 8'hFF;
          pad_model[3] = 8'hFF;
        end
      end
      OP_P1O: begin
        drive_p1i(v);
        if (!prev_model[1] && v[1]) id_model = (id_model + 2'd1) & mask_model;
        prev_model = v;
        if (v == 2'b11) e = {6'h03, ~id_model} & 8'h0F;   // pad id, inverted
        else if (v == 2'b01) e = {4'h0, pad_model[id_model][7:4]};
        else e = {4'h0, pad_model[id_model][3:0]};
        expect_val(2'd1, e);
      end
      OP_P1S: begin
        drive_p1i(v);
        prev_model = v;
      end
      OP_PKT:  send_packet();
      OP_FLAG: expect_val(v, s.exp);
      default: begin   // edge spacing for a control value
        host_write(sgb_pkg::ADDR_CTL, s.data);
        repeat (10) wait_edge();   // past the next bus edge
        gap_div <= s.exp;
        gap_en  <= 1'b1;
        repeat (6) wait_edge();
        gap_en  <= 1'b0;
      end
    endcase
  endtask

  task automatic build_table();
    logic [1:0] seq_a [9] = '{2'b11, 2'b01, 2'b11, 2'b10, 2'b01, 2'b10, 2'b01, 2'b11, 2'b01};
    logic [1:0] seq_b [5] = '{2'b11, 2'b01, 2'b11, 2'b01, 2'b11};
    add(OP_RD, 16'h600F, 0, 8'h61);
    add(OP_RD, 16'h6003, 0, 8'h01);
    add(OP_RD, 16'h6002, 0, 8'h00);
    add(OP_FLAG, 0, 3, 1);                   // cpu_rst held
    add(OP_WR, 16'h6003, 8'hFF, 0);
    add(OP_RD, 16'h6003, 0, 8'hB3);          // unused bits drop
    add(OP_FLAG, 0, 3, 0);
    add(OP_WR, 16'h6003, 8'hB1, 0);          // four players
    for (int i = 0; i < 4; i++) add(OP_WR, 16'h6004 + i, 8'h12 + 8'h22 * i, 0);
    add(OP_RD, 16'h6005, 0, 8'h34);
    foreach (seq_a[i]) add(OP_P1O, 0, seq_a[i], 0);
    add(OP_WR, 16'h6003, 8'h91, 0);          // two players
    add(OP_RD, 16'h6006, 0, 8'hFF);
    add(OP_RD, 16'h6007, 0, 8'hFF);
    add(OP_RD, 16'h6004, 0, 8'h12);
    foreach (seq_b[i]) add(OP_P1O, 0, seq_b[i], 0);
    add(OP_PKT, 0, 0, 0);
    add(OP_RD, 16'h6002, 0, 8'h01);
    for (int i = 0; i < 16; i++) add(OP_PKRD, 16'h7000 + i, 0, i);
    add(OP_RD, 16'h6002, 0, 8'h00);          // cleared by 7000
    // aborted packet
    add(OP_P1S, 0, 2'b00, 0);
    add(OP_P1S, 0, 2'b11, 0);
    add(OP_P1S, 0, 2'b10, 0);
    add(OP_FLAG, 0, 2, 0);
    add(OP_P1S, 0, 2'b01, 0);                // 01 where 11 is due
    add(OP_FLAG, 0, 2, 1);
    add(OP_RD, 16'h6002, 0, 8'h00);
    add(OP_GAP, 0, 8'h00, 8'd16);
    add(OP_GAP, 0, 8'h03, 8'd36);
    n_pkt = 1;
  endtask

  //----------------------------------------------------------------------
  // run control
  //----------------------------------------------------------------------
  always @(posedge CLK) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    host_addr     = '0;
    host_data_in  = '0;
    host_rd_start = 1'b0;
    host_wr_end   = 1'b0;
    p1i           = 2'b00;
    chk_en        = 1'b0;
    chk_sig       = 2'd0;
    chk_exp       = '0;
    gap_en        = 1'b0;
    gap_div       = '0;
    report        = 1'b0;
    lfsr          = 16'd30;
    id_model      = 2'd0;
    mask_model    = 2'd0;
    prev_model    = 2'b00;
    foreach (pad_model[i]) pad_model[i] = 8'hFF;
    build_table();
    limit = steps.size() * 200 + n_pkt * 128 * 3 * 40;
    do @(posedge CLK); while (cpu_ireset_r);
    @(posedge CLK);
    foreach (steps[k]) run_step(steps[k]);
    repeat (2) @(posedge CLK);
    report <= 1'b1;
    @(posedge CLK);
    report <= 1'b0;
    @(posedge CLK);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
verilog/sgb_pkg.sv
verilog/cpu_clock_gen.sv
verilog/joypad_serial_rx.sv
verilog/packet_buffer.sv
verilog/icd2_host_regs.sv
verilog/sgb_icd2.sv
sim/tb_clock_gen.sv
sim/sgb_icd2_checker.sv
sim/sgb_icd2_assertions.sv
sim/tb_sgb_icd2.sv

// ==== Bender.yml ====
package:
  name: sgb_icd2

sources:
  - verilog/sgb_pkg.sv
  - verilog/cpu_clock_gen.sv
  - verilog/joypad_serial_rx.sv
  - verilog/packet_buffer.sv
  - verilog/icd2_host_regs.sv
  - verilog/sgb_icd2.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/sgb_icd2_checker.sv
      - sim/sgb_icd2_assertions.sv
      - sim/tb_sgb_icd2.sv
